//--- design/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

    localparam int ILEN = 32;  // expanded instruction width
    localparam int CLEN = 16;  // compressed instruction width

    // base opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

    // funct3 of the expanded forms
    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;  // lw and sw
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl/sra, split by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b000_0000;
    localparam logic [6:0] F7_ALT  = 7'b010_0000;  // sub, srai

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    // addi x0, x0, 0
    localparam logic [ILEN-1:0] NOP_INST =
        {12'h000, REG_ZERO, F3_ADD, REG_ZERO, OPC_OP_IMM};
    localparam logic [ILEN-1:0] EBREAK_INST =
        {12'h001, REG_ZERO, 3'b000, REG_ZERO, OPC_SYSTEM};

    // low two bits of the fetched word
    typedef enum logic [1:0] {
        Q0     = 2'b00,
        Q1     = 2'b01,
        Q2     = 2'b10,
        Q_FULL = 2'b11   // not compressed
    } quadrant_e;

    // CI / CR view
    typedef struct packed {
        logic [2:0] funct3;
        logic       bit12;
        logic [4:0] rd_rs1;
        logic [4:0] rs2_imm;
        logic [1:0] op;
    } rvc_ci_t;

    // CL / CS / CB view, register fields are x8..x15
    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] imm_hi;   // bits 12:10
        logic [2:0] rs1p;
        logic [1:0] imm_lo;   // bits 6:5
        logic [2:0] rdp;
        logic [1:0] op;
    } rvc_cl_t;

    // CJ view
    typedef struct packed {
        logic [2:0]  funct3;
        logic [10:0] target;  // scrambled jump offset
        logic [1:0]  op;
    } rvc_cj_t;

    // one halfword, read through whichever format funct3 calls for
    typedef union packed {
        rvc_ci_t ci;
        rvc_cl_t cl;
        rvc_cj_t cj;
    } rvc_word_t;

    typedef struct packed {
        logic            req;
        logic [ILEN-1:0] inst;
    } fetch_req_t;

    typedef struct packed {
        logic            ack;
        logic [ILEN-1:0] inst;
    } expand_rsp_t;

endpackage

`default_nettype wire

//--- design/rvc_quadrant0.sv
`timescale 1ns/10ps
`default_nettype none

module rvc_quadrant0 import rvc_pkg::*; (
    input  rvc_word_t       cinst_i,
    output logic [ILEN-1:0] inst_o
);

    logic [4:0]  rd_p;       // rd' or rs2'
    logic [4:0]  rs1_p;
    logic [11:0] addi4_imm;  // zero extended nzuimm
    logic [11:0] word_imm;   // lw/sw byte offset

    // compressed registers live in x8..x15
    assign rd_p  = {2'b01, cinst_i.cl.rdp};
    assign rs1_p = {2'b01, cinst_i.cl.rs1p};

    // nzuimm[5:4|9:6|2|3] in bits 12:5
    assign addi4_imm = {2'b00,
                        cinst_i.cl.imm_hi[0], cinst_i.cl.rs1p,  // [9:6]
                        cinst_i.cl.imm_hi[2:1],                 // [5:4]
                        cinst_i.cl.imm_lo[0],                   // [3]
                        cinst_i.cl.imm_lo[1],                   // [2]
                        2'b00};

    // uimm[5:3] in 12:10, uimm[2|6] in 6:5
    assign word_imm = {5'b0_0000,
                       cinst_i.cl.imm_lo[0],   // [6]
                       cinst_i.cl.imm_hi,      // [5:3]
                       cinst_i.cl.imm_lo[1],   // [2]
                       2'b00};

    always_comb begin
        case (cinst_i.cl.funct3)
            3'b000: begin  // c.addi4spn
                inst_o = {addi4_imm, REG_SP, F3_ADD, rd_p, OPC_OP_IMM};
            end
            3'b010: begin  // c.lw
                inst_o = {word_imm, rs1_p, F3_WORD, rd_p, OPC_LOAD};
            end
            3'b110: begin  // c.sw, rs2' shares the rd' slot
                inst_o = {word_imm[11:5], rd_p, rs1_p, F3_WORD, word_imm[4:0], OPC_STORE};
            end
            default: inst_o = NOP_INST;  // fp and reserved forms
        endcase
    end

endmodule

`default_nettype wire

//--- design/rvc_quadrant1.sv
`timescale 1ns/10ps
`default_nettype none

module rvc_quadrant1 import rvc_pkg::*; (
    input  rvc_word_t       cinst_i,
    output logic [ILEN-1:0] inst_o
);

    logic [4:0]  rd;         // full register field of CI
    logic [4:0]  rd_p;       // rd'/rs1' of the CB/CA group
    logic [4:0]  rs2_p;
    logic [11:0] imm6_sx;    // 6-bit signed immediate, extended
    logic [19:0] lui_imm;
    logic [11:0] a16_imm;    // c.addi16sp offset
    logic [11:0] j_off;      // jump offset, bit 0 always zero
    logic [12:0] b_off;      // branch offset, bit 0 always zero
    logic [10:0] t;
    logic [1:0]  funct2;     // bits 11:10

    assign rd     = cinst_i.ci.rd_rs1;
    assign rd_p   = {2'b01, cinst_i.cl.rs1p};
    assign rs2_p  = {2'b01, cinst_i.cl.rdp};
    assign funct2 = cinst_i.cl.imm_hi[1:0];
    assign t      = cinst_i.cj.target;

    assign imm6_sx = {{7{cinst_i.ci.bit12}}, cinst_i.ci.rs2_imm};
    assign lui_imm = {{15{cinst_i.ci.bit12}}, cinst_i.ci.rs2_imm};

    // nzimm[9] in 12, nzimm[4|6|8:7|5] in 6:2
    assign a16_imm = {{3{cinst_i.ci.bit12}},
                      cinst_i.ci.rs2_imm[2:1],   // [8:7]
                      cinst_i.ci.rs2_imm[3],     // [6]
                      cinst_i.ci.rs2_imm[0],     // [5]
                      cinst_i.ci.rs2_imm[4],     // [4]
                      4'b0000};

    // target holds offset[11|4|9:8|10|6|7|3:1|5]
    assign j_off = {t[10],        // [11]
                    t[6],         // [10]
                    t[8:7],       // [9:8]
                    t[4],         // [7]
                    t[5],         // [6]
                    t[0],         // [5]
                    t[9],         // [4]
                    t[3:1],       // [3:1]
                    1'b0};

    // offset[8|4:3] in 12:10, offset[7:6|2:1|5] in 6:2
    assign b_off = {{4{cinst_i.cl.imm_hi[2]}},
                    cinst_i.cl.imm_hi[2],      // [8]
                    cinst_i.cl.imm_lo,         // [7:6]
                    cinst_i.cl.rdp[0],         // [5]
                    cinst_i.cl.imm_hi[1:0],    // [4:3]
                    cinst_i.cl.rdp[2:1],       // [2:1]
                    1'b0};

    always_comb begin
        inst_o = NOP_INST;
        case (cinst_i.ci.funct3)
            3'b000: inst_o = {imm6_sx, rd, F3_ADD, rd, OPC_OP_IMM};        // c.addi
            3'b010: inst_o = {imm6_sx, REG_ZERO, F3_ADD, rd, OPC_OP_IMM};  // c.li
            3'b011: begin
                if (rd == REG_SP) begin  // c.addi16sp
                    inst_o = {a16_imm, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
                end else begin           // c.lui
                    inst_o = {lui_imm, rd, OPC_LUI};
                end
            end
            3'b100: begin
                case (funct2)
                    2'b00: inst_o = {F7_BASE, cinst_i.ci.rs2_imm, rd_p, F3_SR, rd_p,
                                     OPC_OP_IMM};  // c.srli
                    2'b01: inst_o = {F7_ALT, cinst_i.ci.rs2_imm, rd_p, F3_SR, rd_p,
                                     OPC_OP_IMM};  // c.srai
                    2'b10: inst_o = {imm6_sx, rd_p, F3_AND, rd_p, OPC_OP_IMM};  // c.andi
                    default: begin
                        // register-register group, picked by bits 6:5
                        case (cinst_i.cl.imm_lo)
                            2'b00: inst_o = {F7_ALT, rs2_p, rd_p, F3_ADD, rd_p, OPC_OP};
                            2'b01: inst_o = {F7_BASE, rs2_p, rd_p, F3_XOR, rd_p, OPC_OP};
                            2'b10: inst_o = {F7_BASE, rs2_p, rd_p, F3_OR, rd_p, OPC_OP};
                            default: inst_o = {F7_BASE, rs2_p, rd_p, F3_AND, rd_p, OPC_OP};
                        endcase
                    end
                endcase
            end
            3'b001, 3'b101: begin
                // c.jal links to ra, c.j to zero
                inst_o = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                          cinst_i.ci.funct3[2] ? REG_ZERO : REG_RA, OPC_JAL};
            end
            3'b110: begin  // c.beqz
                inst_o = {b_off[12], b_off[10:5], REG_ZERO, rd_p, F3_BEQ,
                          b_off[4:1], b_off[11], OPC_BRANCH};
            end
            default: begin  // c.bnez
                inst_o = {b_off[12], b_off[10:5], REG_ZERO, rd_p, F3_BNE,
                          b_off[4:1], b_off[11], OPC_BRANCH};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/rvc_quadrant2.sv
`timescale 1ns/10ps
`default_nettype none

module rvc_quadrant2 import rvc_pkg::*; (
    input  rvc_word_t       cinst_i,
    output logic [ILEN-1:0] inst_o
);

    logic [4:0]  rd;          // rd / rs1, full register number
    logic [4:0]  rs2;
    logic [11:0] lwsp_imm;
    logic [11:0] swsp_imm;
    logic        rd_zero;
    logic        rs2_zero;

    assign rd       = cinst_i.ci.rd_rs1;
    assign rs2      = cinst_i.ci.rs2_imm;
    assign rd_zero  = (rd == REG_ZERO);
    assign rs2_zero = (rs2 == REG_ZERO);

    // uimm[5] in 12, uimm[4:2|7:6] in 6:2
    assign lwsp_imm = {4'b0000, rs2[1:0], cinst_i.ci.bit12, rs2[4:2], 2'b00};

    // uimm[5:2|7:6] in 12:7
    assign swsp_imm = {4'b0000, rd[1:0], cinst_i.ci.bit12, rd[4:2], 2'b00};

    always_comb begin
        case (cinst_i.ci.funct3)
            3'b000: inst_o = {F7_BASE, rs2, rd, F3_SLL, rd, OPC_OP_IMM};  // c.slli
            3'b010: inst_o = {lwsp_imm, REG_SP, F3_WORD, rd, OPC_LOAD};    // c.lwsp
            3'b110: begin  // c.swsp
                inst_o = {swsp_imm[11:5], rs2, REG_SP, F3_WORD, swsp_imm[4:0], OPC_STORE};
            end
            3'b100: begin
                // jr / mv / ebreak / jalr / add, split by bit 12 and the zero fields
                if (!cinst_i.ci.bit12) begin
                    if (rs2_zero) begin
                        // c.jr
                        inst_o = {12'h000, rd, F3_JALR, REG_ZERO, OPC_JALR};
                    end else begin
                        inst_o = {F7_BASE, rs2, REG_ZERO, F3_ADD, rd, OPC_OP};  // c.mv
                    end
                end else if (rs2_zero) begin
                    if (rd_zero) begin
                        inst_o = EBREAK_INST;
                    end else begin
                        // c.jalr
                        inst_o = {12'h000, rd, F3_JALR, REG_RA, OPC_JALR};
                    end
                end else begin
                    inst_o = {F7_BASE, rs2, rd, F3_ADD, rd, OPC_OP};  // c.add
                end
            end
            default: inst_o = NOP_INST;  // fp loads/stores
        endcase
    end

endmodule

`default_nettype wire

//--- design/rvc_expander.sv
`timescale 1ns/10ps
`default_nettype none

module rvc_expander import rvc_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  fetch_req_t  fetch_req_i,
    output expand_rsp_t expand_rsp_o
);

    rvc_word_t         cinst;
    quadrant_e         quad;
    logic [ILEN-1:0]   q0_inst;
    logic [ILEN-1:0]   q1_inst;
    logic [ILEN-1:0]   q2_inst;
    logic [ILEN-1:0]   sel_inst;
    expand_rsp_t       rsp_q;     // ack flop and result register

    // same halfword goes to every quadrant
    assign cinst = rvc_word_t'(fetch_req_i.inst[CLEN-1:0]);
    assign quad  = quadrant_e'(fetch_req_i.inst[1:0]);

    rvc_quadrant0 i_quadrant0 (
        .cinst_i (cinst),
        .inst_o  (q0_inst)
    );

    rvc_quadrant1 i_quadrant1 (
        .cinst_i (cinst),
        .inst_o  (q1_inst)
    );

    rvc_quadrant2 i_quadrant2 (
        .cinst_i (cinst),
        .inst_o  (q2_inst)
    );

    always_comb begin
        case (quad)
            Q0:      sel_inst = q0_inst;
            Q1:      sel_inst = q1_inst;
            Q2:      sel_inst = q2_inst;
            default: sel_inst = fetch_req_i.inst;  // full-width word, untouched
        endcase
    end

    // four-phase handshake
    // capture on req rising into an idle stage, release once req is gone
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_q.ack  <= 1'b0;
            rsp_q.inst <= '0;
        end else if (fetch_req_i.req && !rsp_q.ack) begin
            rsp_q.ack  <= 1'b1;
            rsp_q.inst <= sel_inst;
        end else if (!fetch_req_i.req && rsp_q.ack) begin
            rsp_q.ack  <= 1'b0;  // result stays for the consumer
        end
    end

    assign expand_rsp_o = rsp_q;

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 20;  // 40 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_rvc_expander.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rvc_expander import rvc_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;  // ~1500 transactions x 4 cycles, plus margin
    localparam logic [5:0] IMM6_SET [5] = '{6'd0, 6'd1, 6'd31, 6'd32, 6'd63};
    localparam logic [4:0] REG_SET [5]  = '{5'd0, 5'd1, 5'd2, 5'd15, 5'd31};

    logic        clk;
    logic        rst_n;
    fetch_req_t  dut_req;
    expand_rsp_t dut_rsp;
    int unsigned cycles = 0;
    integer      seed = 32'h514b1b63;

    tb_clock_gen i_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

    rvc_expander i_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .fetch_req_i  (dut_req),
        .expand_rsp_o (dut_rsp)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("CHECKS FAILED");
            $fatal(1, "timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // base ISA formats
    function automatic logic [31:0] encode_i(input logic [31:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_s(input logic [31:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] encode_b(input logic [31:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encode_j(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // expected expansion, straight from the C extension tables
    function automatic logic [31:0] ref_expand(input logic [31:0] w);
        logic [15:0] c;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rp_lo;   // x8..x15 from bits 4:2
        logic [4:0]  rp_hi;   // x8..x15 from bits 9:7
        logic [31:0] imm6;
        logic [31:0] jimm;
        logic [31:0] bimm;
        logic [31:0] a16imm;
        logic [31:0] res;
        c      = w[15:0];
        rd     = c[11:7];
        rs2    = c[6:2];
        rp_lo  = {2'b01, c[4:2]};
        rp_hi  = {2'b01, c[9:7]};
        imm6   = {{26{c[12]}}, c[12], c[6:2]};
        jimm   = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        bimm   = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        a16imm = {{22{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
        res    = 32'h0000_0013;  // nop unless decoded below
        case (w[1:0])
            2'b00: begin
                case (c[15:13])
                    3'b000: res = encode_i({22'b0, c[10:7], c[12:11], c[5], c[6], 2'b00},
                                           REG_SP, 3'b000, rp_lo, OPC_OP_IMM);
                    3'b010: res = encode_i({25'b0, c[5], c[12:10], c[6], 2'b00},
                                           rp_hi, 3'b010, rp_lo, OPC_LOAD);
                    3'b110: res = encode_s({25'b0, c[5], c[12:10], c[6], 2'b00}, rp_lo, rp_hi);
                    default: ;
                endcase
            end
            2'b01: begin
                case (c[15:13])
                    3'b000: res = encode_i(imm6, rd, 3'b000, rd, OPC_OP_IMM);
                    3'b001: res = encode_j(jimm, REG_RA);
                    3'b010: res = encode_i(imm6, REG_ZERO, 3'b000, rd, OPC_OP_IMM);
                    3'b011: begin
                        if (rd == REG_SP) begin
                            res = encode_i(a16imm, REG_SP, 3'b000, REG_SP, OPC_OP_IMM);
                        end else begin
                            res = {{14{c[12]}}, c[12], c[6:2], rd, OPC_LUI};
                        end
                    end
                    3'b100: begin
                        case (c[11:10])
                            2'b00: res = encode_i({27'b0, c[6:2]}, rp_hi, 3'b101, rp_hi,
                                                  OPC_OP_IMM);
                            2'b01: res = encode_i({20'b0, 7'b010_0000, c[6:2]}, rp_hi, 3'b101,
                                                  rp_hi, OPC_OP_IMM);
                            2'b10: res = encode_i(imm6, rp_hi, 3'b111, rp_hi, OPC_OP_IMM);
                            default: begin
                                case (c[6:5])
                                    2'b00: res = encode_r(7'b010_0000, rp_lo, rp_hi, 3'b000, rp_hi);
                                    2'b01: res = encode_r(7'b0, rp_lo, rp_hi, 3'b100, rp_hi);
                                    2'b10: res = encode_r(7'b0, rp_lo, rp_hi, 3'b110, rp_hi);
                                    default: res = encode_r(7'b0, rp_lo, rp_hi, 3'b111, rp_hi);
                                endcase
                            end
                        endcase
                    end
                    3'b101: res = encode_j(jimm, REG_ZERO);
                    3'b110: res = encode_b(bimm, rp_hi, 3'b000);
                    default: res = encode_b(bimm, rp_hi, 3'b001);
                endcase
            end
            2'b10: begin
                case (c[15:13])
                    3'b000: res = encode_i({27'b0, c[6:2]}, rd, 3'b001, rd, OPC_OP_IMM);
                    3'b010: res = encode_i({24'b0, c[3:2], c[12], c[6:4], 2'b00},
                                           REG_SP, 3'b010, rd, OPC_LOAD);
                    3'b110: res = encode_s({24'b0, c[8:7], c[12:9], 2'b00}, rs2, REG_SP);
                    3'b100: begin
                        if (!c[12] && rs2 == 5'd0) begin
                            res = encode_i(32'd0, rd, 3'b000, REG_ZERO, OPC_JALR);
                        end else if (!c[12]) begin
                            res = encode_r(7'b0, rs2, REG_ZERO, 3'b000, rd);
                        end else if (rs2 == 5'd0 && rd == 5'd0) begin
                            res = 32'h0010_0073;  // ebreak
                        end else if (rs2 == 5'd0) begin
                            res = encode_i(32'd0, rd, 3'b000, REG_RA, OPC_JALR);
                        end else begin
                            res = encode_r(7'b0, rs2, rd, 3'b000, rd);
                        end
                    end
                    default: ;
                endcase
            end
            default: res = w;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] build_ci(input logic [2:0] f3, input logic b12,
                                             input logic [4:0] r, input logic [4:0] low,
                                             input logic [1:0] op);
        return {16'h0000, f3, b12, r, low, op};
    endfunction

    // offset scrambled into the cj layout
    function automatic logic [31:0] build_cj(input logic [2:0] f3, input logic [11:0] o);
        return {16'h0000, f3, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
    endfunction

    function automatic logic [31:0] build_cb(input logic [2:0] f3, input logic [2:0] rp,
                                             input logic [8:0] o);
        return {16'h0000, f3, o[8], o[4:3], rp, o[7:6], o[2:1], o[5], 2'b01};
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s: got %08h, expected %08h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // called on a falling edge, returns on one
    task automatic transact(input logic [31:0] word, output logic [31:0] result);
        dut_req.inst = word;
        dut_req.req  = 1'b1;
        @(negedge clk);
        while (!dut_rsp.ack) @(negedge clk);
        result      = dut_rsp.inst;
        dut_req.req = 1'b0;
        @(negedge clk);
        while (dut_rsp.ack) @(negedge clk);
    endtask

    task automatic expect_expansion(input logic [31:0] word, input string what);
        logic [31:0] result;
        transact(word, result);
        check_eq(result, ref_expand(word), what);
    endtask

    task automatic test_reset_timing;
        logic [31:0] word;
        logic [31:0] other;
        logic [31:0] expected;
        word     = build_ci(3'b010, 1'b1, 5'd10, 5'd3, 2'b01);  // c.li a0, -29
        other    = build_ci(3'b000, 1'b0, 5'd5, 5'd7, 2'b01);   // c.addi t0, 7
        expected = ref_expand(word);
        check_eq(32'(dut_rsp.ack), 32'd0, "ack after reset");
        check_eq(dut_rsp.inst, 32'd0, "inst after reset");
        dut_req.inst = word;
        dut_req.req  = 1'b1;
        @(negedge clk);  // exactly one rising edge saw req
        check_eq(32'(dut_rsp.ack), 32'd1, "ack one cycle after req");
        check_eq(dut_rsp.inst, expected, "first result");
        // inst is free to move once ack is up
        dut_req.inst = other;
        repeat (10) begin
            @(negedge clk);
            check_eq(32'(dut_rsp.ack), 32'd1, "ack held while req high");
            check_eq(dut_rsp.inst, expected, "result held while req high");
        end
        dut_req.req = 1'b0;
        @(negedge clk);
        check_eq(32'(dut_rsp.ack), 32'd0, "ack one cycle after req drop");
        check_eq(dut_rsp.inst, expected, "result kept after ack drop");
    endtask

    task automatic test_quadrant0;
        logic [7:0]  imm8;
        logic [4:0]  imm5;      // bits 12:10 and 6:5
        logic [31:0] result;
        for (int r = 0; r < 8; r++) begin
            for (int k = 0; k < 9; k++) begin
                imm8 = (k == 8) ? 8'hff : 8'(1 << k);
                expect_expansion({16'h0000, 3'b000, imm8, 3'(r), 2'b00}, "c.addi4spn");
            end
        end
        for (int i = 0; i < 64; i++) begin
            imm5 = 5'(i * 5);   // walks all 32 offsets
            expect_expansion({16'h0000, 3'b010, imm5[4:2], 3'(i >> 3), imm5[1:0], 3'(i), 2'b00},
                             "c.lw");
            expect_expansion({16'h0000, 3'b110, imm5[4:2], 3'(i >> 3), imm5[1:0], 3'(i), 2'b00},
                             "c.sw");
        end
        for (int f = 0; f < 8; f++) begin
            if (f != 0 && f != 2 && f != 6) begin
                transact({16'h0000, 3'(f), 11'h5a5, 2'b00}, result);
                check_eq(result, NOP_INST, "quadrant 0 unsupported funct3");
            end
        end
    endtask

    task automatic test_quadrant1_arith;
        logic [5:0] imm6;
        logic [4:0] rd;
        for (int a = 0; a < 5; a++) begin
            for (int k = 0; k < 5; k++) begin
                rd   = REG_SET[a];
                imm6 = IMM6_SET[k];
                expect_expansion(build_ci(3'b000, imm6[5], rd, imm6[4:0], 2'b01), "c.addi");
                expect_expansion(build_ci(3'b010, imm6[5], rd, imm6[4:0], 2'b01), "c.li");
                expect_expansion(build_ci(3'b011, imm6[5], rd, imm6[4:0], 2'b01),
                                 (rd == REG_SP) ? "c.addi16sp" : "c.lui");
            end
        end
        for (int k = 0; k < 6; k++) begin
            imm6 = 6'(1 << k);
            expect_expansion(build_ci(3'b011, imm6[5], REG_SP, imm6[4:0], 2'b01), "c.addi16sp");
        end
        for (int r = 0; r < 8; r++) begin
            expect_expansion({16'h0000, 3'b100, 3'b000, 3'(r), 5'(r * 4 + 1), 2'b01}, "c.srli");
            expect_expansion({16'h0000, 3'b100, 3'b001, 3'(r), 5'(r * 4 + 3), 2'b01}, "c.srai");
            expect_expansion({16'h0000, 3'b100, 1'(r), 2'b10, 3'(r), 5'(r * 9), 2'b01}, "c.andi");
            for (int s = 0; s < 4; s++) begin
                expect_expansion({16'h0000, 3'b100, 3'b011, 3'(r), 2'(s), 3'(7 - r), 2'b01},
                                 "c.sub/xor/or/and");
            end
        end
    endtask

    task automatic test_quadrant1_flow;
        logic [11:0] joff;
        logic [8:0]  boff;
        for (int b = 1; b < 15; b++) begin
            case (b)
                12:      joff = 12'hffe;  // -2
                13:      joff = 12'h800;  // most negative
                14:      joff = 12'h7fe;  // most positive
                default: joff = 12'(1 << b);
            endcase
            expect_expansion(build_cj(3'b001, joff), "c.jal");
            expect_expansion(build_cj(3'b101, joff), "c.j");
        end
        for (int b = 1; b < 12; b++) begin
            case (b)
                9:       boff = 9'h1fe;
                10:      boff = 9'h100;
                11:      boff = 9'h0fe;
                default: boff = 9'(1 << b);
            endcase
            for (int r = 0; r < 8; r += 7) begin
                expect_expansion(build_cb(3'b110, 3'(r), boff), "c.beqz");
                expect_expansion(build_cb(3'b111, 3'(r), boff), "c.bnez");
            end
        end
    endtask

    task automatic test_quadrant2;
        logic [5:0]  imm6;
        logic [4:0]  rd;
        logic [31:0] result;
        for (int a = 0; a < 5; a++) begin
            rd   = REG_SET[a];
            imm6 = IMM6_SET[a];
            expect_expansion(build_ci(3'b000, 1'b0, rd, 5'(a * 7 + 3), 2'b10), "c.slli");
            expect_expansion(build_ci(3'b010, imm6[5], rd, imm6[4:0], 2'b10), "c.lwsp");
            expect_expansion({16'h0000, 3'b110, imm6, rd, 2'b10}, "c.swsp");
        end
        // rs2 of 0, 2 and 31 against every rd, both values of bit 12
        for (int b12 = 0; b12 < 2; b12++) begin
            for (int a = 0; a < 5; a++) begin
                for (int s = 0; s < 5; s += 2) begin
                    expect_expansion(build_ci(3'b100, 1'(b12), REG_SET[a], REG_SET[s], 2'b10),
                                     "c.jr/mv/ebreak/jalr/add");
                end
            end
        end
        transact(build_ci(3'b100, 1'b1, 5'd0, 5'd0, 2'b10), result);
        check_eq(result, EBREAK_INST, "c.ebreak");
        for (int f = 1; f < 8; f += 2) begin
            transact(build_ci(3'(f), 1'b1, 5'd9, 5'd17, 2'b10), result);
            check_eq(result, NOP_INST, "quadrant 2 unsupported funct3");
        end
    endtask

    task automatic test_random;
        logic [31:0] word;
        logic [31:0] result;
        for (int n = 0; n < 1000; n++) begin
            word = $random(seed);
            if (n % 4 == 0) begin
                word[1:0] = 2'b11;
            end
            transact(word, result);
            if (word[1:0] == 2'b11) begin
                check_eq(result, word, "full word pass-through");
            end else begin
                check_eq(result, ref_expand(word), "random compressed word");
            end
        end
    endtask

    initial begin
        dut_req = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        test_reset_timing;
        test_quadrant0;
        test_quadrant1_arith;
        test_quadrant1_flow;
        test_quadrant2;
        test_random;
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
design/rvc_pkg.sv
design/rvc_quadrant0.sv
design/rvc_quadrant1.sv
design/rvc_quadrant2.sv
design/rvc_expander.sv
tests/tb_clock_gen.sv
tests/tb_rvc_expander.sv

//--- Makefile
TOP := tb_rvc_expander

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log; grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
